/* Makefile */
# Verilator build and run of the SD ADMA2 read engine testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module tb_sd_adma -o sim_adma

run: build
	./obj_dir/sim_adma | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module sd_adma_top

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+include
design/adma_pkg.sv
design/adma_descriptor_fsm.sv
design/read_sequencer.sv
design/axi_burst_reader.sv
design/sd_adma_top.sv
tb/tb_sd_adma.sv

/* design/adma_descriptor_fsm.sv */
`default_nettype none

module adma_descriptor_fsm (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        run_req,
  input  wire  adma_pkg::addr_t      descriptor_base,
  input  wire                        irq_clear,
  input  wire                        seq_ack,
  input  wire                        seq_error,
  input  wire  adma_pkg::data_t      desc_word,
  input  wire                        desc_word_valid,
  output logic                       run_ack,
  output logic                       irq_complete,
  output logic                       irq_error,
  output logic                       seq_req,
  output adma_pkg::addr_t            seq_addr,
  output adma_pkg::words_t           seq_words,
  output adma_pkg::read_kind_t       seq_kind
);

  adma_pkg::adma_state_t state;
  adma_pkg::addr_t       desc_ptr;
  adma_pkg::data_t       desc_w0;
  adma_pkg::data_t       desc_w1;
  logic                  desc_second;
  logic                  seq_done;
  logic                  seq_failed;
  adma_pkg::adma_act_t   act;
  logic                  desc_valid;
  logic                  desc_end;
  logic [15:0]           desc_len;
  adma_pkg::words_t      tfr_words;

  // Descriptor decode
  assign act        = adma_pkg::adma_act_t'(desc_w0[adma_pkg::DESC_ACT_LO +: 2]);
  assign desc_valid = desc_w0[adma_pkg::DESC_VALID_BIT];
  assign desc_end   = desc_w0[adma_pkg::DESC_END_BIT];
  assign desc_len   = desc_w0[adma_pkg::DESC_LEN_LO +: 16];

  // Zero length stands for 65536 bytes
  assign tfr_words = (desc_len == 16'd0) ? adma_pkg::words_t'(16384)
                                         : adma_pkg::words_t'(desc_len[15:2]);

  always_ff @(posedge clock) begin
    if (desc_word_valid) begin
      if (desc_second) begin
        desc_w1 <= desc_word;
      end else begin
        desc_w0 <= desc_word;
      end
    end
  end

  //////////////////////////////////////////////////
  // ADMA2 state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state        <= adma_pkg::ST_STOP;
      run_ack      <= 1'b0;
      irq_complete <= 1'b0;
      irq_error    <= 1'b0;
      seq_req      <= 1'b0;
      seq_done     <= 1'b0;
      seq_failed   <= 1'b0;
      desc_second  <= 1'b0;
    end else begin
      if (irq_clear) begin
        irq_complete <= 1'b0;
        irq_error    <= 1'b0;
      end
      if (desc_word_valid) begin
        desc_second <= ~desc_second;
      end

      // Sequencer handshake, shared by fetch and transfer
      if (seq_req && seq_ack) begin
        seq_req    <= 1'b0;
        seq_done   <= 1'b1;
        seq_failed <= seq_error;
      end

      case (state)
        adma_pkg::ST_STOP: begin
          if (run_ack && !run_req) begin
            run_ack <= 1'b0;
          end else if (run_req && !run_ack) begin
            desc_ptr <= descriptor_base;
            state    <= adma_pkg::ST_FDS;
          end
        end

        adma_pkg::ST_FDS: begin
          if (!seq_req && !seq_ack && !seq_done) begin
            seq_req     <= 1'b1;
            seq_addr    <= desc_ptr;
            seq_words   <= adma_pkg::words_t'(adma_pkg::DESC_BYTES / 4);
            seq_kind    <= adma_pkg::READ_DESC;
            desc_second <= 1'b0;
          end else if (seq_done && !seq_ack) begin
            seq_done <= 1'b0;
            if (seq_failed || !desc_valid) begin
              state     <= adma_pkg::ST_STOP;
              run_ack   <= 1'b1;
              irq_error <= 1'b1;
            end else begin
              state <= adma_pkg::ST_CADR;
            end
          end
        end

        adma_pkg::ST_CADR: begin
          if (act == adma_pkg::ACT_LINK) begin
            desc_ptr <= desc_w1;
          end else begin
            desc_ptr <= desc_ptr + adma_pkg::addr_t'(adma_pkg::DESC_BYTES);
          end
          if (act == adma_pkg::ACT_TRAN) begin
            state <= adma_pkg::ST_TFR;
          end else if (desc_end) begin
            state        <= adma_pkg::ST_STOP;
            run_ack      <= 1'b1;
            irq_complete <= 1'b1;
          end else begin
            state <= adma_pkg::ST_FDS;
          end
        end

        adma_pkg::ST_TFR: begin
          if (!seq_req && !seq_ack && !seq_done) begin
            seq_req   <= 1'b1;
            seq_addr  <= desc_w1;
            seq_words <= tfr_words;
            seq_kind  <= adma_pkg::READ_DATA;
          end else if (seq_done && !seq_ack) begin
            seq_done <= 1'b0;
            if (seq_failed) begin
              state     <= adma_pkg::ST_STOP;
              run_ack   <= 1'b1;
              irq_error <= 1'b1;
            end else if (desc_end) begin
              state        <= adma_pkg::ST_STOP;
              run_ack      <= 1'b1;
              irq_complete <= 1'b1;
            end else begin
              state <= adma_pkg::ST_FDS;
            end
          end
        end

        default: state <= adma_pkg::ST_STOP;
      endcase
    end
  end

  // Request withdrawn only once acknowledged
  assert property (@(posedge clock) disable iff (!reset)
    $fell(seq_req) |-> $past(seq_ack));

  assert property (@(posedge clock) disable iff (!reset)
    state inside {adma_pkg::ST_STOP, adma_pkg::ST_FDS, adma_pkg::ST_CADR, adma_pkg::ST_TFR});

endmodule

`default_nettype wire

/* design/adma_pkg.sv */
`default_nettype none

package adma_pkg;

  // Bus and word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Word counts up to 16384
  localparam int WORDS_W = 15;

  typedef logic [WORDS_W-1:0] words_t;

  // Burst shaping
  localparam int MAX_BURST   = 16;
  localparam int BURST_BYTES = 64;
  localparam int DESC_BYTES  = 8;

  // Fields of descriptor word 0, word 1 is the address
  localparam int DESC_VALID_BIT = 0;
  localparam int DESC_END_BIT   = 1;
  localparam int DESC_ACT_LO    = 4;
  localparam int DESC_LEN_LO    = 16;

  typedef enum logic [1:0] {
    ACT_NOP  = 2'b00,
    ACT_RSV  = 2'b01,
    ACT_TRAN = 2'b10,
    ACT_LINK = 2'b11
  } adma_act_t;

  typedef enum logic [1:0] {
    ST_STOP = 2'b00,
    ST_FDS  = 2'b01,
    ST_CADR = 2'b10,
    ST_TFR  = 2'b11
  } adma_state_t;

  // Destination of read beats
  typedef enum logic {
    READ_DESC = 1'b0,
    READ_DATA = 1'b1
  } read_kind_t;

  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

/* design/axi_burst_reader.sv */
`default_nettype none

module axi_burst_reader (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        burst_req,
  input  wire  adma_pkg::addr_t      burst_addr,
  input  wire  [4:0]                 burst_beats,
  input  wire  adma_pkg::read_kind_t burst_kind,
  input  wire                        m_axi_arready,
  input  wire  adma_pkg::data_t      m_axi_rdata,
  input  wire  [1:0]                 m_axi_rresp,
  input  wire                        m_axi_rlast,
  input  wire                        m_axi_rvalid,
  input  wire                        fifo_full,
  output logic                       burst_ack,
  output logic                       burst_error,
  output adma_pkg::addr_t            m_axi_araddr,
  output logic [7:0]                 m_axi_arlen,
  output logic                       m_axi_arvalid,
  output logic                       m_axi_rready,
  output adma_pkg::data_t            desc_word,
  output logic                       desc_word_valid,
  output adma_pkg::data_t            fifo_wdata,
  output logic                       fifo_wen
);

  logic                 active;
  logic                 failed;
  adma_pkg::read_kind_t kind;
  logic                 beat;

  // Descriptor beats are always taken, data beats wait for FIFO room
  assign m_axi_rready = active && ((kind == adma_pkg::READ_DESC) || !fifo_full);
  assign beat         = m_axi_rvalid && m_axi_rready;

  assign fifo_wen        = beat && (kind == adma_pkg::READ_DATA);
  assign fifo_wdata      = m_axi_rdata;
  assign desc_word_valid = beat && (kind == adma_pkg::READ_DESC);
  assign desc_word       = m_axi_rdata;

  always_ff @(posedge clock) begin
    if (!reset) begin
      m_axi_arvalid <= 1'b0;
      active        <= 1'b0;
      failed        <= 1'b0;
      burst_ack     <= 1'b0;
      burst_error   <= 1'b0;
    end else begin
      if (burst_req && !burst_ack && !active && !m_axi_arvalid) begin
        m_axi_arvalid <= 1'b1;
        m_axi_araddr  <= burst_addr;
        m_axi_arlen   <= 8'(burst_beats - 5'd1);
        kind          <= burst_kind;
        failed        <= 1'b0;
      end

      if (m_axi_arvalid && m_axi_arready) begin
        m_axi_arvalid <= 1'b0;
        active        <= 1'b1;
      end

      // Errors are collected, the burst always runs to rlast
      if (beat) begin
        failed <= failed | m_axi_rresp[1];
        if (m_axi_rlast) begin
          active      <= 1'b0;
          burst_ack   <= 1'b1;
          burst_error <= failed | m_axi_rresp[1];
        end
      end

      if (burst_ack && !burst_req) begin
        burst_ack <= 1'b0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr));

  assert property (@(posedge clock) disable iff (!reset)
    !(fifo_wen && fifo_full));

endmodule

`default_nettype wire

/* design/read_sequencer.sv */
`default_nettype none

module read_sequencer #(
  parameter int MAX_BURST_BEATS = adma_pkg::MAX_BURST
) (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        seq_req,
  input  wire  adma_pkg::addr_t      seq_addr,
  input  wire  adma_pkg::words_t     seq_words,
  input  wire  adma_pkg::read_kind_t seq_kind,
  input  wire                        burst_ack,
  input  wire                        burst_error,
  output logic                       seq_ack,
  output logic                       seq_error,
  output logic                       burst_req,
  output adma_pkg::addr_t            burst_addr,
  output logic [4:0]                 burst_beats,
  output adma_pkg::read_kind_t       burst_kind
);

  localparam logic [4:0] BEATS_MAX = 5'(MAX_BURST_BEATS);

  logic             busy;
  logic             failed;
  adma_pkg::words_t remaining;
  adma_pkg::addr_t  next_addr;
  logic [4:0]       next_beats;

  // Smaller of the remaining count and the burst limit
  assign next_beats = (remaining > adma_pkg::words_t'(BEATS_MAX)) ? BEATS_MAX
                                                                  : remaining[4:0];

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy      <= 1'b0;
      failed    <= 1'b0;
      seq_ack   <= 1'b0;
      seq_error <= 1'b0;
      burst_req <= 1'b0;
    end else begin
      if (!busy && !seq_ack && seq_req) begin
        busy      <= 1'b1;
        failed    <= 1'b0;
        remaining <= seq_words;
        next_addr <= seq_addr;
      end

      // Next burst once the previous handshake is fully closed
      if (busy && !burst_req && !burst_ack) begin
        if (remaining == '0 || failed) begin
          busy      <= 1'b0;
          seq_ack   <= 1'b1;
          seq_error <= failed;
        end else begin
          burst_req   <= 1'b1;
          burst_addr  <= next_addr;
          burst_beats <= next_beats;
          burst_kind  <= seq_kind;
        end
      end

      if (burst_req && burst_ack) begin
        burst_req <= 1'b0;
        remaining <= remaining - adma_pkg::words_t'(burst_beats);
        next_addr <= next_addr + (adma_pkg::addr_t'(burst_beats) << 2);
        failed    <= burst_error;
      end

      if (seq_ack && !seq_req) begin
        seq_ack <= 1'b0;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    burst_req |-> burst_beats inside {[5'd1 : BEATS_MAX]});

endmodule

`default_nettype wire

/* design/sd_adma_top.sv */
`default_nettype none

module sd_adma_top #(
  parameter int MAX_BURST_BEATS = adma_pkg::MAX_BURST
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   run_req,
  input  wire  adma_pkg::addr_t descriptor_base,
  input  wire                   irq_clear,
  input  wire                   m_axi_arready,
  input  wire  adma_pkg::data_t m_axi_rdata,
  input  wire  [1:0]            m_axi_rresp,
  input  wire                   m_axi_rlast,
  input  wire                   m_axi_rvalid,
  input  wire                   fifo_full,
  output wire                   run_ack,
  output wire                   irq_complete,
  output wire                   irq_error,
  output adma_pkg::addr_t       m_axi_araddr,
  output wire  [7:0]            m_axi_arlen,
  output wire  [2:0]            m_axi_arsize,
  output wire  [1:0]            m_axi_arburst,
  output wire                   m_axi_arvalid,
  output wire                   m_axi_rready,
  output adma_pkg::data_t       fifo_wdata,
  output wire                   fifo_wen
);

  // Descriptor FSM to sequencer
  wire                         seq_req;
  wire                         seq_ack;
  wire                         seq_error;
  wire adma_pkg::addr_t        seq_addr;
  wire adma_pkg::words_t       seq_words;
  wire adma_pkg::read_kind_t   seq_kind;

  // Sequencer to AXI reader
  wire                         burst_req;
  wire                         burst_ack;
  wire                         burst_error;
  wire adma_pkg::addr_t        burst_addr;
  wire [4:0]                   burst_beats;
  wire adma_pkg::read_kind_t   burst_kind;

  // Descriptor words back to the FSM
  wire adma_pkg::data_t        desc_word;
  wire                         desc_word_valid;

  assign m_axi_arsize  = adma_pkg::AXI_SIZE_WORD;
  assign m_axi_arburst = adma_pkg::AXI_BURST_INCR;

  adma_descriptor_fsm i_adma_descriptor_fsm (
    .clock           (clock),
    .reset           (reset),
    .run_req         (run_req),
    .descriptor_base (descriptor_base),
    .irq_clear       (irq_clear),
    .seq_ack         (seq_ack),
    .seq_error       (seq_error),
    .desc_word       (desc_word),
    .desc_word_valid (desc_word_valid),
    .run_ack         (run_ack),
    .irq_complete    (irq_complete),
    .irq_error       (irq_error),
    .seq_req         (seq_req),
    .seq_addr        (seq_addr),
    .seq_words       (seq_words),
    .seq_kind        (seq_kind)
  );

  read_sequencer #(
    .MAX_BURST_BEATS (MAX_BURST_BEATS)
  ) i_read_sequencer (
    .clock       (clock),
    .reset       (reset),
    .seq_req     (seq_req),
    .seq_addr    (seq_addr),
    .seq_words   (seq_words),
    .seq_kind    (seq_kind),
    .burst_ack   (burst_ack),
    .burst_error (burst_error),
    .seq_ack     (seq_ack),
    .seq_error   (seq_error),
    .burst_req   (burst_req),
    .burst_addr  (burst_addr),
    .burst_beats (burst_beats),
    .burst_kind  (burst_kind)
  );

  axi_burst_reader i_axi_burst_reader (
    .clock           (clock),
    .reset           (reset),
    .burst_req       (burst_req),
    .burst_addr      (burst_addr),
    .burst_beats     (burst_beats),
    .burst_kind      (burst_kind),
    .m_axi_arready   (m_axi_arready),
    .m_axi_rdata     (m_axi_rdata),
    .m_axi_rresp     (m_axi_rresp),
    .m_axi_rlast     (m_axi_rlast),
    .m_axi_rvalid    (m_axi_rvalid),
    .fifo_full       (fifo_full),
    .burst_ack       (burst_ack),
    .burst_error     (burst_error),
    .m_axi_araddr    (m_axi_araddr),
    .m_axi_arlen     (m_axi_arlen),
    .m_axi_arvalid   (m_axi_arvalid),
    .m_axi_rready    (m_axi_rready),
    .desc_word       (desc_word),
    .desc_word_valid (desc_word_valid),
    .fifo_wdata      (fifo_wdata),
    .fifo_wen        (fifo_wen)
  );

endmodule

`default_nettype wire

/* include/adma_mem_model.svh */
`ifndef ADMA_MEM_MODEL_SVH
`define ADMA_MEM_MODEL_SVH

// Included after clock and the DUT's AXI and FIFO signals are declared

// Sparse word memory, keyed by byte address
adma_pkg::data_t mem [adma_pkg::addr_t];
adma_pkg::data_t expected_q [$];
adma_pkg::addr_t err_addr;
bit              err_enable;
int              fifo_full_pct;

function automatic adma_pkg::data_t mem_read(adma_pkg::addr_t addr);
  if (mem.exists(addr)) begin
    return mem[addr];
  end
  // Unwritten words read back as a pattern of their address
  return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
endfunction

function automatic void put_desc(adma_pkg::addr_t at, bit valid, bit last,
                                 adma_pkg::adma_act_t act, logic [15:0] len,
                                 adma_pkg::addr_t addr);
  adma_pkg::data_t w0;
  w0 = '0;
  w0[adma_pkg::DESC_VALID_BIT] = valid;
  w0[adma_pkg::DESC_END_BIT] = last;
  w0[adma_pkg::DESC_ACT_LO +: 2] = act;
  w0[adma_pkg::DESC_LEN_LO +: 16] = len;
  mem[at] = w0;
  mem[at + 4] = addr;
endfunction

// Walks the chain, fills expected_q, returns {irq_error, irq_complete}
function automatic logic [1:0] model_walk(adma_pkg::addr_t base, output int n_desc);
  adma_pkg::addr_t ptr;
  adma_pkg::addr_t area;
  adma_pkg::data_t w0;
  int              words;
  bit              hit;
  ptr = base;
  n_desc = 0;
  hit = 1'b0;
  while (n_desc < 4096) begin
    w0 = mem_read(ptr);
    area = mem_read(ptr + 4);
    n_desc++;
    if (!w0[adma_pkg::DESC_VALID_BIT]) begin
      return 2'b10;
    end
    if (w0[adma_pkg::DESC_ACT_LO +: 2] == adma_pkg::ACT_TRAN) begin
      words = (w0[31:16] == 16'd0) ? 16384 : int'(w0[31:18]);
      for (int i = 0; i < words; i++) begin
        expected_q.push_back(mem_read(area + 4 * i));
        hit |= err_enable && (area + 4 * i == err_addr);
        // An error response still finishes its own burst
        if (hit && (((i + 1) * 4) % adma_pkg::BURST_BYTES == 0 || i == words - 1)) begin
          return 2'b10;
        end
      end
    end
    if (w0[adma_pkg::DESC_END_BIT]) begin
      return 2'b01;
    end
    if (w0[adma_pkg::DESC_ACT_LO +: 2] == adma_pkg::ACT_LINK) begin
      ptr = area;
    end else begin
      ptr = ptr + adma_pkg::DESC_BYTES;
    end
  end
  return 2'b10;
endfunction

// AXI read slave with random AR and R delays
task automatic axi_slave();
  adma_pkg::addr_t addr;
  int              beats;
  m_axi_arready = 1'b0;
  m_axi_rvalid = 1'b0;
  m_axi_rlast = 1'b0;
  m_axi_rresp = 2'b00;
  m_axi_rdata = '0;
  forever begin
    @(negedge clock);
    if (m_axi_arvalid) begin
      repeat ($urandom_range(0, 3)) @(negedge clock);
      m_axi_arready = 1'b1;
      addr = m_axi_araddr;
      beats = int'(m_axi_arlen) + 1;
      @(negedge clock);
      m_axi_arready = 1'b0;
      for (int i = 0; i < beats; i++) begin
        repeat ($urandom_range(0, 2)) @(negedge clock);
        m_axi_rvalid = 1'b1;
        m_axi_rdata = mem_read(addr);
        m_axi_rresp = (err_enable && addr == err_addr) ? 2'b10 : 2'b00;
        m_axi_rlast = (i == beats - 1);
        do @(posedge clock); while (!m_axi_rready);
        @(negedge clock);
        m_axi_rvalid = 1'b0;
        m_axi_rlast = 1'b0;
        addr += 4;
      end
    end
  end
endtask

// Card side back-pressure
task automatic fifo_driver();
  fifo_full = 1'b0;
  forever begin
    @(negedge clock);
    fifo_full = ($urandom_range(0, 99) < fifo_full_pct);
  end
endtask

`endif

/* tb/tb_sd_adma.sv */
`default_nettype none

module tb_sd_adma;

  logic                  clock;
  logic                  reset;
  logic                  run_req;
  adma_pkg::addr_t       descriptor_base;
  logic                  irq_clear;
  logic                  m_axi_arready;
  adma_pkg::data_t       m_axi_rdata;
  logic [1:0]            m_axi_rresp;
  logic                  m_axi_rlast;
  logic                  m_axi_rvalid;
  logic                  fifo_full;
  wire                   run_ack;
  wire                   irq_complete;
  wire                   irq_error;
  wire adma_pkg::addr_t  m_axi_araddr;
  wire [7:0]             m_axi_arlen;
  wire [2:0]             m_axi_arsize;
  wire [1:0]             m_axi_arburst;
  wire                   m_axi_arvalid;
  wire                   m_axi_rready;
  wire adma_pkg::data_t  fifo_wdata;
  wire                   fifo_wen;

  int n_checks;
  int n_errors;
  int words_seen;
  int budget_cycles = 2000;

  `include "adma_mem_model.svh"

  sd_adma_top #(
    .MAX_BURST_BEATS (adma_pkg::MAX_BURST)
  ) i_sd_adma_top (
    .clock           (clock),
    .reset           (reset),
    .run_req         (run_req),
    .descriptor_base (descriptor_base),
    .irq_clear       (irq_clear),
    .m_axi_arready   (m_axi_arready),
    .m_axi_rdata     (m_axi_rdata),
    .m_axi_rresp     (m_axi_rresp),
    .m_axi_rlast     (m_axi_rlast),
    .m_axi_rvalid    (m_axi_rvalid),
    .fifo_full       (fifo_full),
    .run_ack         (run_ack),
    .irq_complete    (irq_complete),
    .irq_error       (irq_error),
    .m_axi_araddr    (m_axi_araddr),
    .m_axi_arlen     (m_axi_arlen),
    .m_axi_arsize    (m_axi_arsize),
    .m_axi_arburst   (m_axi_arburst),
    .m_axi_arvalid   (m_axi_arvalid),
    .m_axi_rready    (m_axi_rready),
    .fifo_wdata      (fifo_wdata),
    .fifo_wen        (fifo_wen)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input adma_pkg::data_t got,
                            input adma_pkg::data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // exp holds {irq_error, irq_complete}
  task automatic check_irq(input logic got_complete, input logic got_error,
                           input logic [1:0] exp);
    check_flag("irq_complete", got_complete, exp[0]);
    check_flag("irq_error", got_error, exp[1]);
  endtask

  // Word size, incrementing, at most 16 beats
  task automatic check_ar(input logic [7:0] len, input logic [2:0] size,
                          input logic [1:0] burst);
    n_checks++;
    if (len > 8'd15) begin
      n_errors++;
      $display("CHECK FAILED t=%0t m_axi_arlen: got %0d, expected at most 15", $time, len);
    end
    if (size !== 3'd2) begin
      n_errors++;
      $display("CHECK FAILED t=%0t m_axi_arsize: got %0d, expected 2", $time, size);
    end
    if (burst !== 2'd1) begin
      n_errors++;
      $display("CHECK FAILED t=%0t m_axi_arburst: got %0d, expected 1", $time, burst);
    end
  endtask

  // FIFO writes against the model stream
  always @(posedge clock) begin
    if (reset && fifo_wen) begin
      words_seen++;
      if (expected_q.size() == 0) begin
        n_errors++;
        $display("Unexpected FIFO write of %08h at t=%0t, no word was expected",
                 fifo_wdata, $time);
      end else begin
        check_word("fifo_wdata", fifo_wdata, expected_q.pop_front());
      end
    end
    if (reset && m_axi_arvalid && m_axi_arready) begin
      check_ar(m_axi_arlen, m_axi_arsize, m_axi_arburst);
    end
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  task automatic clear_irq();
    @(negedge clock);
    irq_clear = 1'b1;
    @(negedge clock);
    irq_clear = 1'b0;
    check_irq(irq_complete, irq_error, 2'b00);
  endtask

  task automatic run_chain(input adma_pkg::addr_t base, input string name);
    logic [1:0] exp_irq;
    int         n_desc;
    expected_q.delete();
    exp_irq = model_walk(base, n_desc);
    budget_cycles += 300 * expected_q.size() + 2000 * n_desc;
    $display("Run %s: %0d descriptors, %0d words", name, n_desc, expected_q.size());
    @(negedge clock);
    descriptor_base = base;
    run_req = 1'b1;
    do @(negedge clock); while (!run_ack);
    // Flag rises together with run_ack
    check_irq(irq_complete, irq_error, exp_irq);
    repeat ($urandom_range(0, 3)) begin
      @(negedge clock);
      check_flag("run_ack", run_ack, 1'b1);
    end
    run_req = 1'b0;
    @(negedge clock);
    check_flag("run_ack", run_ack, 1'b0);
    // Room for any stray writes
    repeat (40) @(negedge clock);
    if (expected_q.size() != 0) begin
      n_errors++;
      $display("Run %s: %0d expected FIFO words never arrived", name, expected_q.size());
    end
    clear_irq();
  endtask

  task automatic fill_area(input adma_pkg::addr_t area, input int words);
    for (int i = 0; i < words; i++) begin
      mem[area + 4 * i] = $urandom;
    end
  endtask

  task automatic build_random_chain(input adma_pkg::addr_t base,
                                    input adma_pkg::addr_t data_base, input int n_desc);
    adma_pkg::addr_t     ptr;
    adma_pkg::addr_t     area;
    adma_pkg::addr_t     target;
    adma_pkg::adma_act_t act;
    int                  words;
    bit                  is_last;
    ptr = base;
    area = data_base;
    for (int k = 0; k < n_desc; k++) begin
      is_last = (k == n_desc - 1);
      case ($urandom_range(0, 4))
        0: act = adma_pkg::ACT_NOP;
        1: act = adma_pkg::ACT_LINK;
        2: act = adma_pkg::ACT_RSV;
        default: act = adma_pkg::ACT_TRAN;
      endcase
      if (is_last) begin
        act = adma_pkg::ACT_TRAN;
      end
      case (act)
        adma_pkg::ACT_TRAN: begin
          words = $urandom_range(1, 70);
          fill_area(area, words);
          // Low length bits are ignored by the engine
          put_desc(ptr, 1'b1, is_last, act, 16'(words * 4 + $urandom_range(0, 3)), area);
          area += words * 4 + 64;
          ptr += 8;
        end
        adma_pkg::ACT_LINK: begin
          target = ptr + 32'h100;
          put_desc(ptr, 1'b1, 1'b0, act, 16'($urandom), target);
          ptr = target;
        end
        default: begin
          put_desc(ptr, 1'b1, 1'b0, act, 16'($urandom), $urandom);
          ptr += 8;
        end
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic idle_after_reset();
    repeat (20) begin
      @(negedge clock);
      check_flag("run_ack", run_ack, 1'b0);
      check_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
      check_flag("fifo_wen", fifo_wen, 1'b0);
      check_irq(irq_complete, irq_error, 2'b00);
    end
  endtask

  task automatic single_transfer();
    int words;
    words = $urandom_range(1, 200);
    fifo_full_pct = 20;
    fill_area(32'h0010_0000, words);
    put_desc(32'h0001_0000, 1'b1, 1'b1, adma_pkg::ACT_TRAN, 16'(words * 4), 32'h0010_0000);
    run_chain(32'h0001_0000, "single");
  endtask

  task automatic random_chains();
    fifo_full_pct = 40;
    for (int k = 0; k < 4; k++) begin
      build_random_chain(32'h0002_0000 + k * 32'h1000, 32'h0020_0000 + k * 32'h1_0000,
                         $urandom_range(3, 8));
      run_chain(32'h0002_0000 + k * 32'h1000, "chain");
    end
  endtask

  task automatic invalid_descriptor();
    fifo_full_pct = 20;
    fill_area(32'h0030_0000, 10);
    put_desc(32'h0003_0000, 1'b1, 1'b0, adma_pkg::ACT_TRAN, 16'd40, 32'h0030_0000);
    put_desc(32'h0003_0008, 1'b0, 1'b1, adma_pkg::ACT_TRAN, 16'd40, 32'h0030_1000);
    // Never reached
    put_desc(32'h0003_0010, 1'b1, 1'b1, adma_pkg::ACT_TRAN, 16'd40, 32'h0030_2000);
    run_chain(32'h0003_0000, "invalid");
  endtask

  task automatic error_response();
    fifo_full_pct = 20;
    fill_area(32'h0040_0000, 48);
    put_desc(32'h0004_0000, 1'b1, 1'b0, adma_pkg::ACT_NOP, 16'd0, 32'h0);
    put_desc(32'h0004_0008, 1'b1, 1'b1, adma_pkg::ACT_TRAN, 16'd192, 32'h0040_0000);
    err_addr = 32'h0040_0000 + 4 * 20;
    err_enable = 1'b1;
    run_chain(32'h0004_0000, "rresp error");
    err_enable = 1'b0;
  endtask

  task automatic zero_length();
    fifo_full_pct = 10;
    put_desc(32'h0005_0000, 1'b1, 1'b1, adma_pkg::ACT_TRAN, 16'd0, 32'h0080_0000);
    run_chain(32'h0005_0000, "zero length");
  endtask

  initial begin
    void'($urandom(32'hb987));
    reset = 1'b0;
    run_req = 1'b0;
    irq_clear = 1'b0;
    descriptor_base = '0;
    err_enable = 1'b0;
    err_addr = '0;
    fifo_full_pct = 0;
    n_checks = 0;
    n_errors = 0;
    words_seen = 0;
    fork
      axi_slave();
      fifo_driver();
    join_none
    repeat (10) @(negedge clock);
    reset = 1'b1;
    idle_after_reset();
    single_transfer();
    random_chains();
    invalid_descriptor();
    error_response();
    zero_length();
    $display("Checks: %0d, errors: %0d, FIFO words: %0d", n_checks, n_errors, words_seen);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog, budget grows with every run
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= budget_cycles) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", budget_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
